//--- fpAdd128.f
common/fpAddPkg.sv
common/alignIf.sv
common/sumIf.sv
lane/operandAlign.sv
lane/signedMantissaAdder.sv
lane/resultNormalizer.sv
lane/fpAddLane.sv
logic/tagPipe.sv
logic/fpAdd128Top.sv
testbench/fpAddChecker.sv
testbench/fpAdd_assertions.sv
testbench/fpAddTb.sv

//--- Makefile
VERILATOR = verilator
FLAGS = --binary --timing --assert -Wno-fatal
TOP = fpAddTb
FILELIST = fpAdd128.f

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Regression passed"

clean:
	rm -rf obj_dir

//--- testbench/fpAddTb.sv
`timescale 1ns/100ps
`default_nettype none

module fpAddTb;
	import fpAddPkg::*;

	localparam int clkPeriod = 40;
	localparam int resetCycles = 4;
	localparam int streamOps = 200;
	localparam int fixedOps = 32;
	localparam int testCount = 6;
	localparam int drainCycles = pipeLatency + 4;
	localparam longint timeoutNs = longint'(streamOps * 2 + fixedOps + testCount * drainCycles
		+ resetCycles + 8) * clkPeriod * 2;

	logic CLK, rstN, act, sub;
	logic [127:0] opA, opB, result, expWord;
	logic [dstWidth-1:0] dstIn, dstOut;
	logic rdy;
	logic [3:0] nanFlags, infFlags, zeroFlags, expNan, expInf, expZero;
	int errorCount, checkCount, pending;
	int tbErrors, lastErrors, lastChecks;

	fpAdd128Top dut (.*);

	fpAddChecker chk (.*);

	initial begin
		CLK = 1'b0;
		forever #(clkPeriod / 2) CLK = ~CLK;
	end

	initial begin
		#(timeoutNs);
		$display("watchdog: simulation did not complete within %0d ns", timeoutNs);
		$display("Regression failed");
		$finish;
	end

	// ----------------------------------------
	// reference model of one binary32 lane
	// ----------------------------------------
	// returns {nan, inf, zero, word}
	function automatic logic [34:0] refAddLane(input logic [31:0] a, input logic [31:0] b,
		input logic subOp);
		logic sa, sb, nanA, nanB, infA, infB;
		int ea, eb, eMax, lead, e;
		longint ma, mb, s, mag, f;
		sa = a[31];
		sb = b[31] ^ subOp;
		ea = int'(a[30:23]);
		eb = int'(b[30:23]);
		nanA = (ea == 255) && (a[22:0] != 0);
		nanB = (eb == 255) && (b[22:0] != 0);
		infA = (ea == 255) && (a[22:0] == 0);
		infB = (eb == 255) && (b[22:0] == 0);
		if (nanA || nanB || (infA && infB && sa != sb))
			return {3'b100, canonicalNan};
		if (infA || infB)
			return {3'b010, infA ? sa : sb, 8'hff, 23'h0};
		// subnormal inputs count as zero
		ma = (ea == 0) ? 0 : longint'({1'b1, a[22:0]});
		mb = (eb == 0) ? 0 : longint'({1'b1, b[22:0]});
		eMax = (ea > eb) ? ea : eb;
		ma = (eMax - ea >= 24) ? 0 : ma >> (eMax - ea);
		mb = (eMax - eb >= 24) ? 0 : mb >> (eMax - eb);
		s = (sa ? -ma : ma) + (sb ? -mb : mb);
		mag = (s < 0) ? -s : s;
		if (mag == 0)
			return {3'b001, 32'h0};
		lead = 0;
		for (int i = 0; i < 31; i++) begin
			if ((mag >> i) & 1)
				lead = i;
		end
		e = eMax + lead - 23;
		if (e >= 255)
			return {3'b010, s < 0, 8'hff, 23'h0};
		if (e <= 0)
			return {3'b001, 32'h0};
		f = (lead >= 23) ? mag >> (lead - 23) : mag << (23 - lead);
		return {3'b000, s < 0, 8'(e), 23'(f)};
	endfunction

	function automatic logic [31:0] randomOperand();
		logic [31:0] r;
		r = $urandom;
		if (r[0])
			return $urandom;
		return {r[1], 8'(100 + $urandom % 50), 23'($urandom)};
	endfunction

	task automatic sendOp(input logic [127:0] a, input logic [127:0] b, input logic subOp,
		input logic [dstWidth-1:0] tag);
		logic [34:0] r;
		@(negedge CLK);
		for (int k = 0; k < laneCount; k++) begin
			r = refAddLane(a[32*k +: 32], b[32*k +: 32], subOp);
			expWord[32*k +: 32] = r[31:0];
			expNan[k] = r[34];
			expInf[k] = r[33];
			expZero[k] = r[32];
		end
		opA = a;
		opB = b;
		sub = subOp;
		dstIn = tag;
		act = 1'b1;
	endtask

	task automatic idleCycle();
		@(negedge CLK);
		act = 1'b0;
	endtask

	task automatic drainPipe();
		idleCycle();
		while (pending != 0)
			@(negedge CLK);
	endtask

	task automatic closeTest(input string name);
		$display("test %-10s checks %0d errors %0d", name, checkCount - lastChecks,
			errorCount + tbErrors - lastErrors);
		lastChecks = checkCount;
		lastErrors = errorCount + tbErrors;
	endtask

	// ----------------------------------------
	// stimulus
	// ----------------------------------------
	initial begin
		void'($urandom(32'h96f5_73c6));
		tbErrors = 0;
		lastErrors = 0;
		lastChecks = 0;
		rstN = 1'b0;
		act = 1'b0;
		sub = 1'b0;
		opA = '0;
		opB = '0;
		dstIn = '0;
		expWord = '0;
		expNan = '0;
		expInf = '0;
		expZero = '0;

		// reset, rdy must stay low until the first result
		repeat (resetCycles) @(negedge CLK);
		rstN = 1'b1;
		repeat (3) begin
			@(negedge CLK);
			if (rdy !== 1'b0) begin
				$display("error at %0t: rdy went high with nothing accepted", $time);
				tbErrors++;
			end
		end
		sendOp({4{32'h3f80_0000}}, {4{32'h4000_0000}}, 1'b0, 5'd1);
		drainPipe();
		closeTest("reset");

		sendOp({32'h3fc0_0000, 32'h42c8_0000, 32'hc050_0000, 32'h4049_0fdb},
			{32'h3ec0_0000, 32'h3a83_126f, 32'h447a_0000, 32'h402d_f854}, 1'b0, 5'd2);
		sendOp({32'h4120_0000, 32'h3dcc_cccd, 32'h4479_8000, 32'hc2f6_e979},
			{32'h3f00_0000, 32'h4180_0000, 32'hc0a0_0000, 32'hc1c8_0000}, 1'b0, 5'd3);
		for (int i = 0; i < 4; i++)
			sendOp({4{randomOperand()}}, {randomOperand(), randomOperand(), randomOperand(),
				randomOperand()}, 1'b0, 5'(4 + i));
		drainPipe();
		closeTest("normal");

		// cancellation and wide exponent gaps
		sendOp({32'h3f80_0000, 32'h4049_0fdb, 32'h501502f9, 32'h3f80_0000},
			{32'h3fc0_0000, 32'h4049_0fdb, 32'h3f80_0000, 32'h3f80_0000}, 1'b1, 5'd10);
		sendOp({32'h7f00_0000, 32'hc120_0000, 32'h3380_0000, 32'h4b80_0000},
			{32'h3f80_0000, 32'hc120_0000, 32'h3f80_0000, 32'h3f80_0001}, 1'b1, 5'd11);
		drainPipe();
		closeTest("subtract");

		sendOp({32'h7fc0_0000, 32'h7f80_0000, 32'h7f80_0000, 32'hff80_0000},
			{32'h3f80_0000, 32'h40a0_0000, 32'h7f80_0000, 32'hff80_0000}, 1'b0, 5'd12);
		sendOp({32'h4000_0000, 32'hff80_0000, 32'h7f80_0000, 32'h7f80_0001},
			{32'h7f80_0000, 32'h3f80_0000, 32'h7f80_0000, 32'h0000_0000}, 1'b1, 5'd13);
		drainPipe();
		closeTest("special");

		sendOp({32'h7f7f_ffff, 32'hff7f_ffff, 32'h00c0_0000, 32'h0000_0001},
			{32'h7f7f_ffff, 32'hff00_0000, 32'h0080_0000, 32'h0000_0002}, 1'b0, 5'd14);
		sendOp({32'h0100_0000, 32'h0080_0001, 32'h7f7f_ffff, 32'h0040_0000},
			{32'h00ff_ffff, 32'h0080_0000, 32'hff7f_ffff, 32'h3f80_0000}, 1'b1, 5'd15);
		drainPipe();
		closeTest("range");

		// back to back stream with random gaps
		for (int i = 0; i < streamOps; i++) begin
			if ($urandom % 4 == 0)
				idleCycle();
			sendOp({randomOperand(), randomOperand(), randomOperand(), randomOperand()},
				{randomOperand(), randomOperand(), randomOperand(), randomOperand()},
				1'($urandom), 5'(i));
		end
		drainPipe();
		closeTest("stream");

		$display("total checks %0d, errors %0d", checkCount, errorCount + tbErrors);
		if (errorCount + tbErrors == 0)
			$display("Regression passed");
		else
			$display("Regression failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- testbench/fpAdd_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module fpAddAssertions (
	input logic CLK,
	input logic rstN,
	input logic act,
	input logic rdy,
	input logic [127:0] result,
	input logic [3:0] nanFlags
);
	import fpAddPkg::*;

	assert property (@(posedge CLK) !rstN |-> !rdy)
		else $error("rdy high during reset");

	// valid chain is a plain eight cycle delay
	assert property (@(posedge CLK) disable iff (!rstN) rdy == $past(act, pipeLatency))
		else $error("rdy does not follow act by the pipeline latency");

	for (genvar k = 0; k < laneCount; k++) begin : gNan
		assert property (@(posedge CLK) disable iff (!rstN)
			rdy |-> (nanFlags[k] == (result[32*k +: 32] == canonicalNan)))
			else $error("nan flag disagrees with lane result");
	end

endmodule

bind fpAdd128Top fpAddAssertions uAssert (.*);

`default_nettype wire

//--- testbench/fpAddChecker.sv
`timescale 1ns/100ps
`default_nettype none

module fpAddChecker (
	input logic CLK,
	input logic rstN,
	input logic act,
	input logic [fpAddPkg::dstWidth-1:0] dstIn,
	input logic [127:0] expWord,
	input logic [3:0] expNan,
	input logic [3:0] expInf,
	input logic [3:0] expZero,
	input logic rdy,
	input logic [fpAddPkg::dstWidth-1:0] dstOut,
	input logic [127:0] result,
	input logic [3:0] nanFlags,
	input logic [3:0] infFlags,
	input logic [3:0] zeroFlags,
	output int errorCount,
	output int checkCount,
	output int pending
);
	import fpAddPkg::*;

	logic [127:0] wordQ [$];
	logic [11:0] flagQ [$];
	logic [dstWidth-1:0] tagQ [$];
	int cycleQ [$];
	int cycleNo;

	initial begin
		errorCount = 0;
		checkCount = 0;
		pending = 0;
		cycleNo = 0;
	end

	// ----------------------------------------
	// expected values taken on the rising edge
	// ----------------------------------------
	always @(posedge CLK) begin
		if (rstN && act) begin
			wordQ.push_back(expWord);
			flagQ.push_back({expNan, expInf, expZero});
			tagQ.push_back(dstIn);
			cycleQ.push_back(cycleNo);
			pending = pending + 1;
		end
		cycleNo = cycleNo + 1;
	end

	// ----------------------------------------
	// DUT outputs compared on the falling edge
	// ----------------------------------------
	always @(negedge CLK) begin
		logic [127:0] w;
		logic [11:0] f;
		logic [dstWidth-1:0] t;
		int c;
		if (!rstN && rdy) begin
			$display("error at %0t: rdy is high while reset is asserted", $time);
			errorCount = errorCount + 1;
		end else if (rdy && wordQ.size() == 0) begin
			$display("error at %0t: rdy is high but no operation is outstanding", $time);
			errorCount = errorCount + 1;
		end else if (rdy) begin
			w = wordQ.pop_front();
			f = flagQ.pop_front();
			t = tagQ.pop_front();
			c = cycleQ.pop_front();
			pending = pending - 1;
			checkCount = checkCount + 1;
			if (cycleNo - c != pipeLatency) begin
				$display("error at %0t: result arrived after %0d cycles instead of %0d",
					$time, cycleNo - c, pipeLatency);
				errorCount = errorCount + 1;
			end
			for (int k = 0; k < laneCount; k++) begin
				if (result[32*k +: 32] !== w[32*k +: 32]) begin
					$display("mismatch at %0t: result lane %0d expected %h got %h",
						$time, k, w[32*k +: 32], result[32*k +: 32]);
					errorCount = errorCount + 1;
				end
			end
			if (nanFlags !== f[11:8]) begin
				$display("mismatch at %0t: nanFlags expected %b got %b", $time, f[11:8], nanFlags);
				errorCount = errorCount + 1;
			end
			if (infFlags !== f[7:4]) begin
				$display("mismatch at %0t: infFlags expected %b got %b", $time, f[7:4], infFlags);
				errorCount = errorCount + 1;
			end
			if (zeroFlags !== f[3:0]) begin
				$display("mismatch at %0t: zeroFlags expected %b got %b", $time, f[3:0], zeroFlags);
				errorCount = errorCount + 1;
			end
			if (dstOut !== t) begin
				$display("mismatch at %0t: dstOut expected %h got %h", $time, t, dstOut);
				errorCount = errorCount + 1;
			end
		end
	end

endmodule

`default_nettype wire

//--- logic/fpAdd128Top.sv
`timescale 1ns/100ps
`default_nettype none

module fpAdd128Top (
	input logic CLK,
	input logic rstN,
	input logic act,
	input logic sub,
	input logic [127:0] opA,
	input logic [127:0] opB,
	input logic [fpAddPkg::dstWidth-1:0] dstIn,
	output logic rdy,
	output logic [fpAddPkg::dstWidth-1:0] dstOut,
	output logic [127:0] result,
	output logic [3:0] nanFlags,
	output logic [3:0] infFlags,
	output logic [3:0] zeroFlags
);
	import fpAddPkg::*;

	// ----------------------------------------
	// four independent binary32 lanes
	// ----------------------------------------
	for (genvar k = 0; k < laneCount; k++) begin : gLane
		fpAddLane uLane (
			.CLK (CLK),
			.opA (opA[32*k +: 32]),
			.opB (opB[32*k +: 32]),
			.sub (sub),
			.laneResult (result[32*k +: 32]),
			.nan (nanFlags[k]),
			.inf (infFlags[k]),
			.zero (zeroFlags[k])
		);
	end

	// valid and tag, same latency as the lanes
	tagPipe uTagPipe (
		.CLK (CLK),
		.rstN (rstN),
		.act (act),
		.dstIn (dstIn),
		.rdy (rdy),
		.dstOut (dstOut)
	);

endmodule

`default_nettype wire

//--- logic/tagPipe.sv
`timescale 1ns/100ps
`default_nettype none

module tagPipe (
	input logic CLK,
	input logic rstN,
	input logic act,
	input logic [fpAddPkg::dstWidth-1:0] dstIn,
	output logic rdy,
	output logic [fpAddPkg::dstWidth-1:0] dstOut
);
	import fpAddPkg::*;

	logic [pipeLatency-1:0] validPipe;
	logic [dstWidth-1:0] tagStage [pipeLatency];

	always_ff @(posedge CLK or negedge rstN) begin
		if (!rstN)
			validPipe <= '0;
		else
			validPipe <= {validPipe[pipeLatency-2:0], act};
	end

	// tags ride beside the valid bits
	always_ff @(posedge CLK) begin
		tagStage[0] <= dstIn;
		for (int i = 1; i < pipeLatency; i++) begin
			tagStage[i] <= tagStage[i-1];
		end
	end

	assign rdy = validPipe[pipeLatency-1];
	assign dstOut = tagStage[pipeLatency-1];

endmodule

`default_nettype wire

//--- lane/fpAddLane.sv
`timescale 1ns/100ps
`default_nettype none

module fpAddLane (
	input logic CLK,
	input fpAddPkg::laneWord opA,
	input fpAddPkg::laneWord opB,
	input logic sub,
	output fpAddPkg::laneWord laneResult,
	output logic nan,
	output logic inf,
	output logic zero
);

	// three stage groups chained through two interfaces
	alignIf alignBus ();
	sumIf sumBus ();

	// stages 1-2
	operandAlign uAlign (
		.CLK (CLK),
		.opA (opA),
		.opB (opB),
		.sub (sub),
		.alignBus (alignBus.src)
	);

	// stages 3-5
	signedMantissaAdder uAdder (
		.CLK (CLK),
		.alignBus (alignBus.dst),
		.sumBus (sumBus.src)
	);

	// stages 6-8
	resultNormalizer uNorm (
		.CLK (CLK),
		.sumBus (sumBus.dst),
		.laneResult (laneResult),
		.nan (nan),
		.inf (inf),
		.zero (zero)
	);

endmodule

`default_nettype wire

//--- lane/resultNormalizer.sv
`timescale 1ns/100ps
`default_nettype none

module resultNormalizer (
	input logic CLK,
	sumIf.dst sumBus,
	output fpAddPkg::laneWord laneResult,
	output logic nan,
	output logic inf,
	output logic zero
);
	import fpAddPkg::*;

	logic [4:0] leadPos;

	logic [sumWidth-2:0] mag6;
	logic [4:0] lead6;
	expValue exp6;
	logic sign6, zero6;
	logic [2:0] flags6;

	logic [sumWidth-2:0] shifted;

	logic [sigWidth-1:0] norm7;
	expValue exp7;
	logic sign7, zero7;
	logic [2:0] flags7;

	logic overflow, underflow;

	// highest set bit of the magnitude
	always_comb begin
		leadPos = '0;
		for (int i = 0; i < sumWidth - 1; i++) begin
			if (sumBus.magnitude[i])
				leadPos = 5'(i);
		end
	end

	// ----------------------------------------
	// stage 6 registers the leading one
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		mag6 <= sumBus.magnitude[sumWidth-2:0];
		lead6 <= leadPos;
		exp6 <= sumBus.expCommon;
		sign6 <= sumBus.sumSign;
		zero6 <= ~|sumBus.magnitude;
		flags6 <= {sumBus.isNan, sumBus.isInf, sumBus.infSign};
	end

	// leading one moves to the top and the low bits drop off
	assign shifted = mag6 << (5'(sigWidth) - lead6);

	// stage 7 normalizes and moves the exponent with the leading one
	always_ff @(posedge CLK) begin
		norm7 <= shifted[sumWidth-2:1];
		exp7 <= exp6 + expValue'(lead6) - expValue'(sigWidth - 1);
		sign7 <= sign6;
		zero7 <= zero6;
		flags7 <= flags6;
	end

	// top bit set means the exponent went negative
	assign overflow = ~exp7[expWidth] && (exp7 >= expValue'(expMax));
	assign underflow = exp7[expWidth] || (exp7 == '0);

	// ----------------------------------------
	// stage 8 packs the result
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		nan <= 1'b0;
		inf <= 1'b0;
		zero <= 1'b0;
		if (flags7[2]) begin
			laneResult <= canonicalNan;
			nan <= 1'b1;
		end else if (flags7[1] || overflow) begin
			laneResult <= {flags7[1] ? flags7[0] : sign7, expWidth'(expMax), fracWidth'(0)};
			inf <= 1'b1;
		end else if (zero7 || underflow) begin
			// flush to +0
			laneResult <= '0;
			zero <= 1'b1;
		end else begin
			laneResult <= {sign7, exp7[expWidth-1:0], norm7[fracWidth-1:0]};
		end
	end

endmodule

`default_nettype wire

//--- lane/signedMantissaAdder.sv
`timescale 1ns/100ps
`default_nettype none

module signedMantissaAdder (
	input logic CLK,
	alignIf.dst alignBus,
	sumIf.src sumBus
);
	import fpAddPkg::*;

	logic [sumWidth-1:0] extA, extB;

	logic [sumWidth-1:0] negA3, negB3;
	expValue exp3;
	logic [2:0] flags3;

	logic [sumWidth-1:0] sum4;
	expValue exp4;
	logic [2:0] flags4;

	assign extA = sumWidth'(alignBus.sigA);
	assign extB = sumWidth'(alignBus.sigB);

	// ----------------------------------------
	// stage 3 negates the operands with the sign set
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		negA3 <= alignBus.signA ? -extA : extA;
		negB3 <= alignBus.signB ? -extB : extB;
		// two zero operands carry no exponent
		exp3 <= alignBus.bothZero ? '0 : alignBus.expCommon;
		flags3 <= {alignBus.isNan, alignBus.isInf, alignBus.infSign};
	end

	// stage 4 adds
	always_ff @(posedge CLK) begin
		sum4 <= negA3 + negB3;
		exp4 <= exp3;
		flags4 <= flags3;
	end

	// ----------------------------------------
	// stage 5 takes magnitude and sign
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		sumBus.magnitude <= sum4[sumWidth-1] ? -sum4 : sum4;
		// a zero sum has a clear top bit so cancellation gives +0
		sumBus.sumSign <= sum4[sumWidth-1];
		sumBus.expCommon <= exp4;
		sumBus.isNan <= flags4[2];
		sumBus.isInf <= flags4[1];
		sumBus.infSign <= flags4[0];
	end

endmodule

`default_nettype wire

//--- lane/operandAlign.sv
`timescale 1ns/100ps
`default_nettype none

module operandAlign (
	input logic CLK,
	input fpAddPkg::laneWord opA,
	input fpAddPkg::laneWord opB,
	input logic sub,
	alignIf.src alignBus
);
	import fpAddPkg::*;

	logic [expWidth-1:0] expAIn, expBIn;
	logic [fracWidth-1:0] fracAIn, fracBIn;

	logic signA1, signB1;
	logic [expWidth-1:0] expA1, expB1;
	logic [fracWidth-1:0] fracA1, fracB1;
	logic nanA1, nanB1, infA1, infB1, zeroA1, zeroB1;
	logic [expWidth-1:0] shiftA1, shiftB1;

	logic [sigWidth-1:0] sigAFull, sigBFull;

	assign expAIn = opA[fracWidth +: expWidth];
	assign expBIn = opB[fracWidth +: expWidth];
	assign fracAIn = opA[fracWidth-1:0];
	assign fracBIn = opB[fracWidth-1:0];

	// ----------------------------------------
	// stage 1: unpack and classify
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		signA1 <= opA[31];
		signB1 <= opB[31] ^ sub;
		expA1 <= expAIn;
		expB1 <= expBIn;
		fracA1 <= fracAIn;
		fracB1 <= fracBIn;
		nanA1 <= (expAIn == expWidth'(expMax)) && (fracAIn != '0);
		nanB1 <= (expBIn == expWidth'(expMax)) && (fracBIn != '0);
		infA1 <= (expAIn == expWidth'(expMax)) && (fracAIn == '0);
		infB1 <= (expBIn == expWidth'(expMax)) && (fracBIn == '0);
		// subnormals count as zero
		zeroA1 <= (expAIn == '0);
		zeroB1 <= (expBIn == '0);
		// only the smaller operand gets a shift
		shiftA1 <= (expAIn < expBIn) ? expBIn - expAIn : '0;
		shiftB1 <= (expBIn < expAIn) ? expAIn - expBIn : '0;
	end

	// no hidden one for a zero operand
	assign sigAFull = zeroA1 ? '0 : {1'b1, fracA1};
	assign sigBFull = zeroB1 ? '0 : {1'b1, fracB1};

	// ----------------------------------------
	// stage 2: align and resolve specials
	// ----------------------------------------
	always_ff @(posedge CLK) begin
		alignBus.sigA <= (shiftA1 >= expWidth'(sigWidth)) ? '0 : sigAFull >> shiftA1;
		alignBus.sigB <= (shiftB1 >= expWidth'(sigWidth)) ? '0 : sigBFull >> shiftB1;
		alignBus.expCommon <= expValue'((expA1 >= expB1) ? expA1 : expB1);
		alignBus.signA <= signA1;
		alignBus.signB <= signB1;
		// inf - inf is invalid
		alignBus.isNan <= nanA1 | nanB1 | (infA1 & infB1 & (signA1 ^ signB1));
		alignBus.isInf <= ~(nanA1 | nanB1) & (infA1 | infB1) & ~(infA1 & infB1 & (signA1 ^ signB1));
		alignBus.infSign <= infA1 ? signA1 : signB1;
		alignBus.bothZero <= zeroA1 & zeroB1;
	end

endmodule

`default_nettype wire

//--- common/sumIf.sv
`timescale 1ns/100ps
`default_nettype none

interface sumIf;
	import fpAddPkg::*;

	// magnitude of the signed sum, top bit always clear
	logic [sumWidth-1:0] magnitude;
	logic sumSign;
	expValue expCommon;
	logic isNan;
	logic isInf;
	logic infSign;

	modport src (output magnitude, sumSign, expCommon, isNan, isInf, infSign);
	modport dst (input magnitude, sumSign, expCommon, isNan, isInf, infSign);

endinterface

`default_nettype wire

//--- common/alignIf.sv
`timescale 1ns/100ps
`default_nettype none

interface alignIf;
	import fpAddPkg::*;

	expValue expCommon;
	logic [sigWidth-1:0] sigA;
	logic [sigWidth-1:0] sigB;
	logic signA;
	logic signB;
	logic isNan;
	logic isInf;
	logic infSign;
	logic bothZero;

	modport src (output expCommon, sigA, sigB, signA, signB, isNan, isInf, infSign, bothZero);
	modport dst (input expCommon, sigA, sigB, signA, signB, isNan, isInf, infSign, bothZero);

endinterface

`default_nettype wire

//--- common/fpAddPkg.sv
`default_nettype none

package fpAddPkg;

	// ----------------------------------------
	// lane geometry
	// ----------------------------------------
	localparam int laneCount = 4;
	localparam int expWidth = 8;
	localparam int fracWidth = 23;

	// hidden one included
	localparam int sigWidth = fracWidth + 1;

	// sign and carry on top of the significand
	localparam int sumWidth = sigWidth + 2;

	// all ones exponent, inf and nan
	localparam int expMax = 255;

	// ----------------------------------------
	// pipeline and tag
	// ----------------------------------------
	localparam int pipeLatency = 8;
	localparam int dstWidth = 5;

	// ----------------------------------------
	// types
	// ----------------------------------------
	typedef logic [31:0] laneWord;

	// extra top bit shows overflow and underflow of the exponent
	typedef logic [expWidth:0] expValue;

	// quiet nan with a clear sign bit
	localparam laneWord canonicalNan = 32'h7fff_ffff;

endpackage

`default_nettype wire
